// File: wts_sound_pkg.sv
/*
 * Wave-table sound audio definitions
 * Channel count and the widths of samples, volume, panning, rate and output
 */
package wts_sound_pkg;

	parameter int NUM_CHANNELS = 6;

	// Signed wave sample as stored in wave memory
	typedef logic signed [7:0] sample_t;

	typedef logic [3:0] volume_t;

	// Bit 1 routes to left, bit 0 routes to right
	typedef logic [1:0] pan_t;

	typedef logic [11:0] freq_t;

	// One-hot slot ring, bit n is the slot of channel n
	typedef logic [5:0] phase_t;

	typedef logic [11:0] audio_t;

endpackage

// File: wts_bus_pkg.sv
/*
 * Wave-table sound memory bus definitions
 * Wave and bank addressing, CPU channel select and the CPU access states
 */
package wts_bus_pkg;

	typedef logic [4:0] wave_addr_t;

	// Index of the channel within the bank on top, sample index below
	typedef logic [6:0] bank_addr_t;

	// Bit 0 picks the bank, bits 2:1 the channel within that bank
	typedef logic [2:0] chan_id_t;

	typedef enum logic [1:0] {
		idle,
		wait_slot,
		read_return
	} cpu_state_t;

endpackage

// File: wts_bank_if.sv
/*
 * Wave bank access port
 * Carries the RAM port of one bank and the CPU request path into its arbiter
 */
interface wts_bank_if import wts_sound_pkg::*, wts_bus_pkg::*; ();

	logic			we;
	bank_addr_t		a;
	sample_t		d;
	sample_t		q;

	logic			cpu_req;
	logic			cpu_we;
	bank_addr_t		cpu_a;
	sample_t		cpu_d;
	logic			cpu_grant;

	modport arbiter (output we, a, d, cpu_grant, input cpu_req, cpu_we, cpu_a, cpu_d);
	modport ram (input we, a, d, output q);
	// The CPU side also sees q to pick up read data
	modport cpu (output cpu_req, cpu_we, cpu_a, cpu_d, input cpu_grant, q);

endinterface

// File: wts_wave_ram.sv
/*
 * Wave memory bank
 * 128 x 8 single-port RAM with a registered read
 */
module wts_wave_ram import wts_sound_pkg::*, wts_bus_pkg::*; (
	input	logic		clk,
	wts_bank_if.ram		bus
);

	localparam int DEPTH = 2 ** $bits(bank_addr_t);

	sample_t	mem [DEPTH];

	// Read returns the old byte when the same address is written
	always_ff @(posedge clk) begin
		if (bus.we) begin
			mem[bus.a] <= bus.d;
		end
		bus.q <= mem[bus.a];
	end

endmodule

// File: wts_wave_addr.sv
/*
 * Channel wave address generator
 * Divides the slot rate by the frequency count and steps a 32-entry pointer
 */
module wts_wave_addr import wts_sound_pkg::*, wts_bus_pkg::*; (
	input	logic		clk,
	input	logic		nreset,
	input	logic		active,
	input	logic		key_on,
	input	freq_t		reg_frequency_count,
	output	wave_addr_t	wave_a
);

	freq_t		divider;
	logic		step;

	// The pointer moves once every reg_frequency_count + 1 slots
	assign step = (divider == reg_frequency_count);

	// ------------------------------------------------------------
	// Divider
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			divider <= '0;
		end
		else if (key_on) begin
			divider <= '0;
		end
		else if (active) begin
			if (step) begin
				divider <= '0;
			end
			else begin
				divider <= divider + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------
	// Wave pointer, wraps after the last sample
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			wave_a <= '0;
		end
		else if (key_on) begin
			wave_a <= '0;
		end
		else if (active && step) begin
			wave_a <= wave_a + 1'b1;
		end
	end

endmodule

// File: wts_cpu_access.sv
/*
 * CPU wave memory access
 * Latches a CPU read or write, waits for a free slot on the addressed bank
 * and returns read data with a one-cycle strobe
 */
module wts_cpu_access import wts_sound_pkg::*, wts_bus_pkg::*; (
	input	logic		clk,
	input	logic		nreset,
	input	chan_id_t	sram_id,
	input	wave_addr_t	sram_a,
	input	sample_t	sram_d,
	input	logic		sram_oe,
	input	logic		sram_we,
	output	sample_t	sram_q,
	output	logic		sram_q_en,
	wts_bank_if.cpu		even_bank,
	wts_bank_if.cpu		odd_bank
);

	cpu_state_t	state;
	logic		req_odd;
	logic		req_we;
	bank_addr_t	req_a;
	sample_t	req_d;
	sample_t	q_hold;
	logic		start;
	logic		granted;
	sample_t	bank_q;

	assign start	= (state == idle) && (sram_oe || sram_we);
	assign granted	= req_odd ? odd_bank.cpu_grant : even_bank.cpu_grant;
	assign bank_q	= req_odd ? odd_bank.q : even_bank.q;

	// ------------------------------------------------------------
	// Request FSM
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			state	<= idle;
			req_odd	<= 1'b0;
			req_we	<= 1'b0;
		end
		else begin
			case (state)
				idle: begin
					if (start) begin
						state	<= wait_slot;
						req_odd	<= sram_id[0];
						req_we	<= sram_we;
					end
				end
				wait_slot: begin
					if (granted) begin
						state <= req_we ? idle : read_return;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			req_a <= {sram_id[2:1], sram_a};
			req_d <= sram_d;
		end
		if (state == read_return) begin
			q_hold <= bank_q;
		end
	end

	// Only the selected bank sees the request
	assign even_bank.cpu_req	= (state == wait_slot) && !req_odd;
	assign odd_bank.cpu_req		= (state == wait_slot) && req_odd;
	assign even_bank.cpu_we		= req_we;
	assign odd_bank.cpu_we		= req_we;
	assign even_bank.cpu_a		= req_a;
	assign odd_bank.cpu_a		= req_a;
	assign even_bank.cpu_d		= req_d;
	assign odd_bank.cpu_d		= req_d;

	// RAM output still holds the CPU byte in the cycle after the grant
	assign sram_q_en	= (state == read_return);
	assign sram_q		= sram_q_en ? bank_q : q_hold;

endmodule

// File: wts_bank_arbiter.sv
/*
 * Wave bank arbiter
 * Hands the bank to its channel in owned slots and to the CPU otherwise
 */
module wts_bank_arbiter import wts_sound_pkg::*, wts_bus_pkg::*; #(
	parameter int BANK = 0
) (
	input	phase_t				phase,
	input	wave_addr_t [2:0]	chan_a,
	wts_bank_if.arbiter			bus
);

	localparam int SLOTS = 3;

	logic		owned;
	bank_addr_t	chan_addr;

	// ------------------------------------------------------------
	// Channel slot decode
	// ------------------------------------------------------------
	// Channel k of this bank sits in ring slot 2 * k + BANK
	always_comb begin
		owned		= 1'b0;
		chan_addr	= '0;
		for (int k = 0; k < SLOTS; k++) begin
			if (phase[2 * k + BANK]) begin
				owned		= 1'b1;
				chan_addr	= {2'(k), chan_a[k]};
			end
		end
	end

	// ------------------------------------------------------------
	// RAM port
	// ------------------------------------------------------------
	assign bus.cpu_grant	= !owned && bus.cpu_req;
	assign bus.we			= bus.cpu_grant && bus.cpu_we;
	assign bus.a			= owned ? chan_addr : bus.cpu_a;
	assign bus.d			= bus.cpu_d;

endmodule

// File: wts_mixer.sv
/*
 * Channel mixer
 * Scales each returning sample by volume, pans it, integrates one frame
 * and puts out the sums as offset binary
 */
module wts_mixer import wts_sound_pkg::*; #(
	parameter int NUM_CHANNELS = 6
) (
	input	logic							clk,
	input	logic							nreset,
	input	phase_t							phase,
	input	sample_t						even_q,
	input	sample_t						odd_q,
	input	volume_t [NUM_CHANNELS-1:0]		reg_volume,
	input	pan_t [NUM_CHANNELS-1:0]		reg_enable,
	output	audio_t							left_out,
	output	audio_t							right_out
);

	phase_t				phase_d;
	sample_t			sample;
	volume_t			volume;
	pan_t				pan;
	logic signed [12:0]	product;
	audio_t				scaled;
	audio_t				left_add;
	audio_t				right_add;
	audio_t				left_integ;
	audio_t				right_integ;
	audio_t				left_sum;
	audio_t				right_sum;

	// ------------------------------------------------------------
	// Select the channel whose data is on the RAM outputs
	// ------------------------------------------------------------
	always_comb begin
		sample	= even_q;
		volume	= '0;
		pan		= '0;
		for (int n = 0; n < NUM_CHANNELS; n++) begin
			if (phase_d[n]) begin
				sample	= (n % 2 == 1) ? odd_q : even_q;
				volume	= reg_volume[n];
				pan		= reg_enable[n];
			end
		end
	end

	assign product		= sample * $signed({1'b0, volume});
	assign scaled		= audio_t'(product >>> 4);
	assign left_add		= pan[1] ? scaled : '0;
	assign right_add	= pan[0] ? scaled : '0;
	assign left_sum		= left_integ + left_add;
	assign right_sum	= right_integ + right_add;

	// ------------------------------------------------------------
	// Integrator and output registers
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			phase_d		<= '0;
			left_integ	<= '0;
			right_integ	<= '0;
			left_out	<= 12'h800;
			right_out	<= 12'h800;
		end
		else begin
			phase_d		<= phase;
			// First channel of the frame starts a fresh sum
			left_integ	<= phase_d[0] ? left_add : left_sum;
			right_integ	<= phase_d[0] ? right_add : right_sum;
			if (phase_d[NUM_CHANNELS-1]) begin
				left_out	<= {~left_sum[11], left_sum[10:0]};
				right_out	<= {~right_sum[11], right_sum[10:0]};
			end
		end
	end

endmodule

// File: wts_core.sv
/*
 * Wave-table sound core
 * Six channels over two wave banks, driven by a six-slot phase ring
 */
module wts_core import wts_sound_pkg::*, wts_bus_pkg::*; (
	input	logic							clk,
	input	logic							nreset,
	input	logic [NUM_CHANNELS-1:0]		key_on,
	input	freq_t [NUM_CHANNELS-1:0]		reg_frequency_count,
	input	volume_t [NUM_CHANNELS-1:0]		reg_volume,
	input	pan_t [NUM_CHANNELS-1:0]		reg_enable,
	input	chan_id_t						sram_id,
	input	wave_addr_t						sram_a,
	input	sample_t						sram_d,
	input	logic							sram_oe,
	input	logic							sram_we,
	output	sample_t						sram_q,
	output	logic							sram_q_en,
	output	audio_t							left_out,
	output	audio_t							right_out
);

	phase_t							phase;
	wave_addr_t [NUM_CHANNELS-1:0]	wave_a;

	wts_bank_if even_bus ();
	wts_bank_if odd_bus ();

	// ------------------------------------------------------------
	// Phase ring, one slot per channel
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			phase <= 6'b000001;
		end
		else begin
			phase <= {phase[4:0], phase[5]};
		end
	end

	for (genvar n = 0; n < NUM_CHANNELS; n++) begin : g_chan
		wts_wave_addr u_wave_addr (
			.clk					(clk),
			.nreset					(nreset),
			.active					(phase[n]),
			.key_on					(key_on[n]),
			.reg_frequency_count	(reg_frequency_count[n]),
			.wave_a					(wave_a[n])
		);
	end

	// ------------------------------------------------------------
	// Wave banks, A C E even and B D F odd
	// ------------------------------------------------------------
	wts_bank_arbiter #(.BANK(0)) u_even_arbiter (
		.phase	(phase),
		.chan_a	({wave_a[4], wave_a[2], wave_a[0]}),
		.bus	(even_bus)
	);

	wts_bank_arbiter #(.BANK(1)) u_odd_arbiter (
		.phase	(phase),
		.chan_a	({wave_a[5], wave_a[3], wave_a[1]}),
		.bus	(odd_bus)
	);

	wts_wave_ram u_even_ram (.clk(clk), .bus(even_bus));
	wts_wave_ram u_odd_ram (.clk(clk), .bus(odd_bus));

	wts_cpu_access u_cpu_access (
		.clk		(clk),
		.nreset		(nreset),
		.sram_id	(sram_id),
		.sram_a		(sram_a),
		.sram_d		(sram_d),
		.sram_oe	(sram_oe),
		.sram_we	(sram_we),
		.sram_q		(sram_q),
		.sram_q_en	(sram_q_en),
		.even_bank	(even_bus),
		.odd_bank	(odd_bus)
	);

	wts_mixer #(.NUM_CHANNELS(NUM_CHANNELS)) u_mixer (
		.clk		(clk),
		.nreset		(nreset),
		.phase		(phase),
		.even_q		(even_bus.q),
		.odd_q		(odd_bus.q),
		.reg_volume	(reg_volume),
		.reg_enable	(reg_enable),
		.left_out	(left_out),
		.right_out	(right_out)
	);

endmodule

// File: tb_wts_util.svh
/*
 * Testbench helpers for the wave-table sound core
 * LFSR stimulus, expected output of one frame and bounded waits
 */
`ifndef TB_WTS_UTIL_SVH
`define TB_WTS_UTIL_SVH

// Galois LFSR, stepped once per bit taken
function automatic logic [31:0] take_bits(input int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		r = {r[30:0], lfsr[0]};
	end
	return r;
endfunction

// Bit 6 differs from the sign bit, so the magnitude is at least 64
function automatic sample_t random_sample();
	sample_t s;
	s = sample_t'(take_bits(8));
	s[6] = ~s[7];
	return s;
endfunction

// Offset-binary output of one frame; side 1 is left and side 0 is right
function automatic audio_t frame_model(input int side);
	int sum;
	sum = 2048;
	for (int n = 0; n < NUM_CHANNELS; n++) begin
		if (reg_enable[n][side]) begin
			sum += (int'(chan_sample[n]) * int'(reg_volume[n])) >>> 4;
		end
	end
	return audio_t'(sum);
endfunction

task automatic compare_audio(input string name, input audio_t got, input audio_t exp);
	assert (got == exp) else begin
		value_errors++;
		$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
	end
endtask

// Returns the number of falling edges since the read request
task automatic wait_q_en(output int cycles);
	int i;
	cycles = 0;
	i = 1;
	while (cycles == 0 && i <= 8) begin
		if (sram_q_en) begin
			cycles = i;
		end
		else begin
			@(negedge clk);
			i++;
		end
	end
	if (cycles == 0) begin
		timeouts++;
		$display("Timeout at %0t: sram_q_en never rose after a read", $time);
	end
endtask

task automatic wait_outputs(input audio_t exp_l, input audio_t exp_r, input int limit,
		output int cycles);
	int i;
	cycles = 0;
	i = 0;
	while (cycles == 0 && i < limit) begin
		@(negedge clk);
		i++;
		if (left_out == exp_l && right_out == exp_r) begin
			cycles = i;
		end
	end
	if (cycles == 0) begin
		timeouts++;
		$display("Timeout at %0t: outputs did not reach %h %h", $time, exp_l, exp_r);
	end
endtask

`endif

// File: tb_wts.sv
/*
 * Testbench for the wave-table sound core
 * Checks CPU wave access, mixing, panning and the wave pointer rate
 */
module tb_wts import wts_sound_pkg::*, wts_bus_pkg::*; ();

	logic						clk;
	logic						nreset;
	logic [NUM_CHANNELS-1:0]	key_on;
	freq_t [NUM_CHANNELS-1:0]	reg_frequency_count;
	volume_t [NUM_CHANNELS-1:0]	reg_volume;
	pan_t [NUM_CHANNELS-1:0]	reg_enable;
	chan_id_t					sram_id;
	wave_addr_t					sram_a;
	sample_t					sram_d;
	logic						sram_oe;
	logic						sram_we;
	sample_t					sram_q;
	logic						sram_q_en;
	audio_t						left_out;
	audio_t						right_out;

	logic [31:0]	lfsr = 32'h0c3a_06b8;
	sample_t		shadow [256];
	sample_t		chan_sample [NUM_CHANNELS];
	logic [7:0]		written [$];
	int				value_errors = 0;
	int				timeouts = 0;
	int				since_change;
	audio_t			prev_l;
	audio_t			prev_r;

	`include "tb_wts_util.svh"

	wts_core dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Outputs may only move once per six-slot frame
	always @(negedge clk) begin
		since_change = since_change + 1;
		if (!nreset) begin
			since_change = 6;
		end
		else if (left_out != prev_l || right_out != prev_r) begin
			assert (since_change >= 6) else begin
				value_errors++;
				$display("[ERROR] %0t output change gap got %0d expected 6", $time,
					since_change);
			end
			since_change = 0;
		end
		prev_l = left_out;
		prev_r = right_out;
	end

	// ------------------------------------------------------------
	// CPU wave access
	// ------------------------------------------------------------
	task automatic cpu_write(input int ch, input wave_addr_t a, input sample_t d);
		sram_id = chan_id_t'(ch);
		sram_a = a;
		sram_d = d;
		sram_we = 1'b1;
		shadow[{sram_id, a}] = d;
		@(negedge clk);
		sram_we = 1'b0;
		repeat (4) @(negedge clk);
	endtask

	task automatic cpu_read_check(input int ch, input wave_addr_t a);
		int cycles;
		sram_id = chan_id_t'(ch);
		sram_a = a;
		sram_oe = 1'b1;
		@(negedge clk);
		sram_oe = 1'b0;
		wait_q_en(cycles);
		assert (cycles == 2 || cycles == 3) else begin
			value_errors++;
			$display("[ERROR] %0t sram_q_en delay got %0d expected 2 or 3", $time, cycles);
		end
		assert (sram_q == shadow[{sram_id, a}]) else begin
			value_errors++;
			$display("[ERROR] %0t sram_q got %h expected %h", $time, sram_q,
				shadow[{sram_id, a}]);
		end
		// The read strobe lasts a single cycle
		@(negedge clk);
		assert (!sram_q_en) else begin
			value_errors++;
			$display("[ERROR] %0t sram_q_en got 1 expected 0 after the strobe", $time);
		end
		repeat (2) @(negedge clk);
	endtask

	task automatic fill_wave(input int ch, input sample_t low_half, input sample_t high_half);
		for (int i = 0; i < 32; i++) begin
			cpu_write(ch, wave_addr_t'(i), (i < 16) ? low_half : high_half);
		end
		chan_sample[ch] = shadow[{3'(ch), 5'd0}];
	endtask

	task automatic check_outputs();
		audio_t exp_l;
		audio_t exp_r;
		int cycles;
		exp_l = frame_model(1);
		exp_r = frame_model(0);
		wait_outputs(exp_l, exp_r, 40, cycles);
		repeat (18) begin
			@(negedge clk);
			compare_audio("left_out", left_out, exp_l);
			compare_audio("right_out", right_out, exp_r);
		end
	endtask

	// ------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------
	initial begin
		int ch;
		int cycles;
		int elapsed;
		sample_t c;
		wave_addr_t a;
		audio_t exp_al;
		audio_t exp_ar;
		audio_t exp_bl;
		audio_t exp_br;
		nreset = 1'b0;
		key_on = '0;
		reg_frequency_count = '0;
		reg_volume = '0;
		reg_enable = '0;
		sram_id = '0;
		sram_a = '0;
		sram_d = '0;
		sram_oe = 1'b0;
		sram_we = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		nreset = 1'b1;

		repeat (12) begin
			@(negedge clk);
			compare_audio("left_out", left_out, 12'h800);
			compare_audio("right_out", right_out, 12'h800);
			assert (!sram_q_en) else begin
				value_errors++;
				$display("[ERROR] %0t sram_q_en got 1 expected 0", $time);
			end
		end

		repeat (24) begin
			ch = int'(take_bits(3));
			a = wave_addr_t'(take_bits(5));
			c = sample_t'(take_bits(8));
			cpu_write(ch, a, c);
			written.push_back({sram_id, sram_a});
		end
		foreach (written[i]) begin
			cpu_read_check(int'(written[i][7:5]), written[i][4:0]);
		end

		// Each wave holds one constant so the sum does not depend on the pointers
		for (ch = 0; ch < NUM_CHANNELS; ch++) begin
			c = random_sample();
			fill_wave(ch, c, c);
			reg_volume[ch] = volume_t'(8 + take_bits(3));
		end
		reg_enable = '1;
		check_outputs();

		for (int p = 2; p >= 0; p--) begin
			reg_enable = '1;
			reg_enable[take_bits(3) % 6] = pan_t'(p);
			check_outputs();
		end

		reg_enable = '1;
		ch = int'(take_bits(3) % 6);
		c = random_sample();
		fill_wave(ch, c, ~c);
		chan_sample[ch] = ~c;
		exp_bl = frame_model(1);
		exp_br = frame_model(0);
		chan_sample[ch] = c;
		exp_al = frame_model(1);
		exp_ar = frame_model(0);
		// Each half lasts 16 pointer steps of six cycles times the rate
		for (int fc = 0; fc < 2; fc++) begin
			reg_frequency_count[ch] = freq_t'(fc);
			key_on[ch] = 1'b1;
			@(negedge clk);
			key_on[ch] = 1'b0;
			repeat (24) @(negedge clk);
			wait_outputs(exp_al, exp_ar, 40, cycles);
			elapsed = 25 + cycles;
			wait_outputs(exp_bl, exp_br, 96 * (fc + 1) + 40, cycles);
			elapsed += cycles;
			// The restarted pointer reaches the second half one half period after key_on
			assert (elapsed > 96 * (fc + 1) && elapsed <= 96 * (fc + 1) + 18) else begin
				value_errors++;
				$display("[ERROR] %0t key_on to second half got %0d expected %0d to %0d",
					$time, elapsed, 96 * (fc + 1) + 1, 96 * (fc + 1) + 18);
			end
			wait_outputs(exp_al, exp_ar, 96 * (fc + 1) + 40, cycles);
			assert (cycles == 96 * (fc + 1)) else begin
				value_errors++;
				$display("[ERROR] %0t half-wave period got %0d expected %0d", $time, cycles,
					96 * (fc + 1));
			end
		end

		$display("Checks done with %0d value errors and %0d timeouts", value_errors, timeouts);
		if (value_errors == 0 && timeouts == 0) begin
			$display("TEST PASS");
		end
		else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: tb.f
+incdir+.
wts_sound_pkg.sv
wts_bus_pkg.sv
wts_bank_if.sv
wts_wave_ram.sv
wts_wave_addr.sv
wts_cpu_access.sv
wts_bank_arbiter.sv
wts_mixer.sv
wts_core.sv
tb_wts.sv

// File: run.sh
#!/bin/sh
# Builds the wave-table sound testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_wts -f tb.f -o sim_wts
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_wts > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAIL" sim.log; then
	exit 1
fi
exit 0
